/* files.f */
src/rv_pkg.sv
src/rv_pc_reg.sv
src/rv_idu.sv
src/rv_regfile.sv
src/rv_exu.sv
src/rv_core_top.sv
test/rv_core_checker.sv
test/rv_core_tb.sv

/* src/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    // instruction port
    output logic      [XLEN-1:0] inst_addr_o,
    input  wire logic [XLEN-1:0] inst_i,
    // data port
    output logic                 mem_wen_o,
    output logic      [XLEN-1:0] mem_waddr_o,
    output logic      [XLEN-1:0] mem_wdata_o,
    output logic      [7:0]      mem_wmask_o,
    output logic      [XLEN-1:0] mem_raddr_o,
    input  wire logic [XLEN-1:0] mem_rdata_i
);

    logic [XLEN-1:0]       pc;
    logic                  run;
    logic                  jump_en;
    logic [XLEN-1:0]       jump_addr;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic [XLEN-1:0]       jop1;
    logic [XLEN-1:0]       jop2;
    logic [XLEN-1:0]       store_data;
    logic [REG_ADDR_W-1:0] rd;
    logic                  dec_reg_wen;
    logic                  dec_mem_wen;
    logic                  dec_mem_ren;
    logic                  dec_jump;
    logic                  dec_jalr;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [XLEN-1:0]       wb_data;
    logic                  wb_wen;

    assign inst_addr_o = pc;

    rv_pc_reg #(
        .RESET_PC (RESET_PC)
    ) i_rv_pc_reg (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .jump_en_i   (jump_en),
        .jump_addr_i (jump_addr),
        .pc_o        (pc),
        .run_o       (run)
    );

    rv_idu i_rv_idu (
        .inst_i       (inst_i),
        .pc_i         (pc),
        .run_i        (run),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .op1_o        (op1),
        .op2_o        (op2),
        .jop1_o       (jop1),
        .jop2_o       (jop2),
        .store_data_o (store_data),
        .rd_o         (rd),
        .reg_wen_o    (dec_reg_wen),
        .mem_wen_o    (dec_mem_wen),
        .mem_ren_o    (dec_mem_ren),
        .jump_o       (dec_jump),
        .jalr_o       (dec_jalr)
    );

    rv_regfile i_rv_regfile (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .wen_i    (wb_wen),
        .waddr_i  (wb_addr),
        .wdata_i  (wb_data)
    );

    rv_exu i_rv_exu (
        .op1_i        (op1),
        .op2_i        (op2),
        .jop1_i       (jop1),
        .jop2_i       (jop2),
        .store_data_i (store_data),
        .rd_i         (rd),
        .reg_wen_i    (dec_reg_wen),
        .mem_wen_i    (dec_mem_wen),
        .mem_ren_i    (dec_mem_ren),
        .jump_i       (dec_jump),
        .jalr_i       (dec_jalr),
        .mem_rdata_i  (mem_rdata_i),
        .jump_en_o    (jump_en),
        .jump_addr_o  (jump_addr),
        .mem_wen_o    (mem_wen_o),
        .mem_waddr_o  (mem_waddr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_wmask_o  (mem_wmask_o),
        .mem_raddr_o  (mem_raddr_o),
        .waddr_o      (wb_addr),
        .wdata_o      (wb_data),
        .reg_wen_o    (wb_wen)
    );

endmodule

`default_nettype wire

/* src/rv_exu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exu
    import rv_pkg::*;
(
    // operands and strobes from decode
    input  wire logic [XLEN-1:0]       op1_i,
    input  wire logic [XLEN-1:0]       op2_i,
    input  wire logic [XLEN-1:0]       jop1_i,
    input  wire logic [XLEN-1:0]       jop2_i,
    input  wire logic [XLEN-1:0]       store_data_i,
    input  wire logic [REG_ADDR_W-1:0] rd_i,
    input  wire logic                  reg_wen_i,
    input  wire logic                  mem_wen_i,
    input  wire logic                  mem_ren_i,
    input  wire logic                  jump_i,
    input  wire logic                  jalr_i,
    // load data
    input  wire logic [XLEN-1:0]       mem_rdata_i,
    // to pc
    output logic                       jump_en_o,
    output logic      [XLEN-1:0]       jump_addr_o,
    // to data memory
    output logic                       mem_wen_o,
    output logic      [XLEN-1:0]       mem_waddr_o,
    output logic      [XLEN-1:0]       mem_wdata_o,
    output logic      [7:0]            mem_wmask_o,
    output logic      [XLEN-1:0]       mem_raddr_o,
    // to register file
    output logic      [REG_ADDR_W-1:0] waddr_o,
    output logic      [XLEN-1:0]       wdata_o,
    output logic                       reg_wen_o
);

    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] jump_sum;
    wb_sel_e         wb_sel;

    // one adder serves writeback values and memory addresses
    assign alu_res  = op1_i + op2_i;
    assign jump_sum = jop1_i + jop2_i;

    // jump target, jalr drops bit 0
    assign jump_en_o = jump_i;
    always_comb begin
        jump_addr_o = '0;
        if (jump_i) begin
            jump_addr_o = jalr_i ? (jump_sum & ~XLEN'(1)) : jump_sum;
        end
    end

    // store port
    assign mem_wen_o   = mem_wen_i;
    assign mem_waddr_o = mem_wen_i ? alu_res : '0;
    assign mem_wdata_o = mem_wen_i ? store_data_i : '0;
    assign mem_wmask_o = mem_wen_i ? WMASK_WORD : 8'b0;

    // load address
    assign mem_raddr_o = mem_ren_i ? alu_res : '0;

    // writeback source
    always_comb begin
        if (!reg_wen_i) begin
            wb_sel = WB_NONE;
        end else if (mem_ren_i) begin
            wb_sel = WB_MEM;
        end else begin
            wb_sel = WB_ALU;
        end
    end

    always_comb begin
        case (wb_sel)
            WB_ALU:  wdata_o = alu_res;
            WB_MEM:  wdata_o = mem_rdata_i;
            default: wdata_o = '0;
        endcase
    end

    assign waddr_o   = rd_i;
    assign reg_wen_o = reg_wen_i;

endmodule

`default_nettype wire

/* src/rv_idu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_idu
    import rv_pkg::*;
(
    input  wire logic [XLEN-1:0]       inst_i,
    input  wire logic [XLEN-1:0]       pc_i,
    input  wire logic                  run_i,
    input  wire logic [XLEN-1:0]       rs1_data_i,
    input  wire logic [XLEN-1:0]       rs2_data_i,
    output logic      [REG_ADDR_W-1:0] rs1_addr_o,
    output logic      [REG_ADDR_W-1:0] rs2_addr_o,
    output logic      [XLEN-1:0]       op1_o,
    output logic      [XLEN-1:0]       op2_o,
    output logic      [XLEN-1:0]       jop1_o,
    output logic      [XLEN-1:0]       jop2_o,
    output logic      [XLEN-1:0]       store_data_o,
    output logic      [REG_ADDR_W-1:0] rd_o,
    output logic                       reg_wen_o,
    output logic                       mem_wen_o,
    output logic                       mem_ren_o,
    output logic                       jump_o,
    output logic                       jalr_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    alu_src_e        alu_src;
    logic            dec_reg_wen;
    logic            dec_mem_wen;
    logic            dec_mem_ren;
    logic            dec_jump;
    logic            dec_jalr;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_o       = inst_i[11:7];

    // immediate formats
    assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{(XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{(XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    // opcode decode, unknown encodings keep every enable low
    always_comb begin
        alu_src     = SRC_RS1_IMMI;
        dec_reg_wen = 1'b0;
        dec_mem_wen = 1'b0;
        dec_mem_ren = 1'b0;
        dec_jump    = 1'b0;
        dec_jalr    = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                dec_reg_wen = (funct3 == F3_ADDI);
            end
            OPC_LOAD: begin
                dec_reg_wen = (funct3 == F3_LW);
                dec_mem_ren = (funct3 == F3_LW);
            end
            OPC_STORE: begin
                alu_src     = SRC_RS1_IMMS;
                dec_mem_wen = (funct3 == F3_SW);
            end
            OPC_LUI: begin
                alu_src     = SRC_ZERO_UIMM;
                dec_reg_wen = 1'b1;
            end
            OPC_AUIPC: begin
                alu_src     = SRC_PC_UIMM;
                dec_reg_wen = 1'b1;
            end
            OPC_JAL: begin
                alu_src     = SRC_PC_4;
                dec_reg_wen = 1'b1;
                dec_jump    = 1'b1;
            end
            OPC_JALR: begin
                alu_src     = SRC_PC_4;
                dec_reg_wen = (funct3 == F3_JALR);
                dec_jump    = (funct3 == F3_JALR);
                dec_jalr    = (funct3 == F3_JALR);
            end
            default: ;
        endcase
    end

    // alu operand pair
    always_comb begin
        case (alu_src)
            SRC_RS1_IMMS: begin
                op1_o = rs1_data_i;
                op2_o = imm_s;
            end
            SRC_ZERO_UIMM: begin
                op1_o = '0;
                op2_o = imm_u;
            end
            SRC_PC_UIMM: begin
                op1_o = pc_i;
                op2_o = imm_u;
            end
            SRC_PC_4: begin
                op1_o = pc_i;
                op2_o = XLEN'(4);
            end
            default: begin
                op1_o = rs1_data_i;
                op2_o = imm_i;
            end
        endcase
    end

    // jump target operands, rs1 based only for jalr
    assign jop1_o = dec_jalr ? rs1_data_i : pc_i;
    assign jop2_o = dec_jalr ? imm_i : imm_j;

    assign store_data_o = rs2_data_i;

    // nothing leaves the decoder before the core runs
    assign reg_wen_o = run_i & dec_reg_wen;
    assign mem_wen_o = run_i & dec_mem_wen;
    assign mem_ren_o = run_i & dec_mem_ren;
    assign jump_o    = run_i & dec_jump;
    assign jalr_o    = run_i & dec_jalr;

endmodule

`default_nettype wire

/* src/rv_pc_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pc_reg
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            jump_en_i,
    input  wire logic [XLEN-1:0] jump_addr_i,
    output logic      [XLEN-1:0] pc_o,
    output logic                 run_o
);

    logic [XLEN-1:0] pc_next;

    // sequential fetch unless the current instruction jumps
    assign pc_next = jump_en_i ? jump_addr_i : pc_o + XLEN'(4);

    // run goes high one edge after reset release
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o  <= RESET_PC;
            run_o <= 1'b0;
        end else begin
            run_o <= 1'b1;
            // hold the reset address until the core is running
            if (run_o) begin
                pc_o <= pc_next;
            end
        end
    end

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // datapath and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // funct3 codes of the supported instructions
    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_JALR = 3'b000;

    // byte lanes of a full word store
    localparam logic [7:0] WMASK_WORD = 8'b0000_1111;

    // alu operand pair selection
    typedef enum logic [2:0] {
        SRC_RS1_IMMI  = 3'd0,
        SRC_RS1_IMMS  = 3'd1,
        SRC_ZERO_UIMM = 3'd2,
        SRC_PC_UIMM   = 3'd3,
        SRC_PC_4      = 3'd4
    } alu_src_e;

    // writeback source
    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_ALU  = 2'd1,
        WB_MEM  = 2'd2
    } wb_sel_e;

endpackage

`default_nettype wire

/* src/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
    import rv_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic [REG_ADDR_W-1:0] raddr1_i,
    input  wire logic [REG_ADDR_W-1:0] raddr2_i,
    output logic      [XLEN-1:0]       rdata1_o,
    output logic      [XLEN-1:0]       rdata2_o,
    input  wire logic                  wen_i,
    input  wire logic [REG_ADDR_W-1:0] waddr_i,
    input  wire logic [XLEN-1:0]       wdata_i
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    // x0 never gets written, so it stays at its reset value of zero
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational read ports
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

`default_nettype wire

/* test/rv_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input wire logic            clk_i,
    input wire logic            rst_n_i,
    input wire logic [XLEN-1:0] inst_addr_i,
    input wire logic            mem_wen_i,
    input wire logic [XLEN-1:0] mem_waddr_i,
    input wire logic [XLEN-1:0] mem_wdata_i,
    input wire logic [7:0]      mem_wmask_i
);

    // expected streams, filled by the model before each run
    logic [XLEN-1:0] exp_pc_q [$];
    logic [XLEN-1:0] exp_addr_q [$];
    logic [XLEN-1:0] exp_data_q [$];
    logic [7:0]      exp_mask_q [$];
    int              cyc;
    int              errors;

    task automatic push_fetch(input logic [XLEN-1:0] pc);
        exp_pc_q.push_back(pc);
    endtask

    task automatic push_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                              input logic [7:0] mask);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
        exp_mask_q.push_back(mask);
    endtask

    task automatic report_mismatch(input string field, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] exp);
        $display("MISMATCH at %0t: %s got %h expected %h", $time, field, got, exp);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_fetch();
        logic [XLEN-1:0] pc;
        if (exp_pc_q.size() == 0) begin
            report_problem("fetch seen after the expected fetch stream ran out");
        end else begin
            pc = exp_pc_q.pop_front();
            if (inst_addr_i !== pc) report_mismatch("fetch address", inst_addr_i, pc);
        end
    endtask

    task automatic check_store();
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
        logic [7:0]      mask;
        if (exp_addr_q.size() == 0) begin
            report_problem("store seen with no store expected");
        end else begin
            addr = exp_addr_q.pop_front();
            data = exp_data_q.pop_front();
            mask = exp_mask_q.pop_front();
            if (mem_waddr_i !== addr) report_mismatch("store address", mem_waddr_i, addr);
            if (mem_wdata_i !== data) report_mismatch("store data", mem_wdata_i, data);
            if (mem_wmask_i !== mask) report_mismatch("store mask", 32'(mem_wmask_i), 32'(mask));
        end
    endtask

    // leftovers mean the core stopped short of the model
    task automatic close_test(output int errs);
        if (exp_pc_q.size() != 0) report_problem("expected fetch addresses were never seen");
        if (exp_addr_q.size() != 0) report_problem("expected stores were never seen");
        exp_pc_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_mask_q.delete();
        errs = errors;
        errors = 0;
    endtask

    // sample mid-cycle, the first two cycles after release hold the reset address
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            cyc = 0;
            if (mem_wen_i !== 1'b0) report_problem("store strobe active during reset");
        end else begin
            cyc++;
            if (cyc <= 2) begin
                if (inst_addr_i !== RESET_PC) report_mismatch("reset fetch", inst_addr_i, RESET_PC);
            end else begin
                check_fetch();
            end
            if (cyc == 1 && mem_wen_i !== 1'b0) begin
                report_problem("store strobe active before the core runs");
            end else if (mem_wen_i === 1'b1) begin
                check_store();
            end
        end
    end

endmodule

`default_nettype wire

/* test/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb
    import rv_pkg::*;
();

    localparam logic [XLEN-1:0] RESET_PC = 32'h0;
    localparam logic [31:0] NOP = 32'h0000_0013;
    localparam int LEN_ALU = 10;
    localparam int LEN_MEM = 8;
    localparam int LEN_JMP = 7;
    localparam int LEN_RAND = 300;
    localparam int LEN_HALF = 150;
    localparam int NUM_RESETS = 6;
    localparam int TIMEOUT =
        (LEN_ALU + LEN_MEM + LEN_JMP + LEN_RAND + 2 * LEN_HALF + 16 * NUM_RESETS) * 2;

    logic            clk;
    logic            rst_n;
    logic [XLEN-1:0] inst_addr;
    logic [XLEN-1:0] inst;
    logic            mem_wen;
    logic [XLEN-1:0] mem_waddr;
    logic [XLEN-1:0] mem_wdata;
    logic [7:0]      mem_wmask;
    logic [XLEN-1:0] mem_raddr;
    logic [XLEN-1:0] mem_rdata;
    logic [XLEN-1:0] imem [64];
    logic [XLEN-1:0] dmem [64];
    logic [XLEN-1:0] m_regs [32];
    logic [XLEN-1:0] m_dmem [64];
    logic [15:0]     lfsr;
    int              cycles;
    int              tests_run;
    int              tests_failed;
    int              total_errors;

    rv_core_top #(.RESET_PC(RESET_PC)) i_rv_core_top (
        .clk_i(clk), .rst_n_i(rst_n), .inst_addr_o(inst_addr), .inst_i(inst),
        .mem_wen_o(mem_wen), .mem_waddr_o(mem_waddr), .mem_wdata_o(mem_wdata),
        .mem_wmask_o(mem_wmask), .mem_raddr_o(mem_raddr), .mem_rdata_i(mem_rdata)
    );

    rv_core_checker #(.RESET_PC(RESET_PC)) i_rv_core_checker (
        .clk_i(clk), .rst_n_i(rst_n), .inst_addr_i(inst_addr), .mem_wen_i(mem_wen),
        .mem_waddr_i(mem_waddr), .mem_wdata_i(mem_wdata), .mem_wmask_i(mem_wmask)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // data memory with combinational read and write on the clock edge
    assign mem_rdata = dmem[mem_raddr[7:2]];
    always @(posedge clk) begin
        if (mem_wen) dmem[mem_waddr[7:2]] <= mem_wdata;
    end

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] itype_word(input logic [6:0] opc, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] utype_word(input logic [6:0] opc, input logic [4:0] rd,
                                               input logic [31:0] imm);
        return {imm[19:0], rd, opc};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // immediates as the isa defines them
    function automatic logic [31:0] i_imm(input logic [31:0] w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic logic [31:0] s_imm(input logic [31:0] w);
        return {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    function automatic logic [31:0] j_imm(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    // reference model that runs n instructions and queues the expected streams
    task automatic model_run(input int n);
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] w;
        logic [31:0] rs1v;
        logic [31:0] res;
        logic [31:0] addr;
        logic        wr;
        for (int r = 0; r < 32; r++) m_regs[r] = '0;
        pc = RESET_PC;
        for (int k = 0; k < n; k++) begin
            if (k > 0) i_rv_core_checker.push_fetch(pc);
            w = imem[pc[7:2]];
            rs1v = m_regs[w[19:15]];
            npc = pc + 32'd4;
            wr = 1'b1;
            res = '0;
            case (w[6:0])
                OPC_OP_IMM: res = rs1v + i_imm(w);
                OPC_LUI:    res = {w[31:12], 12'h0};
                OPC_AUIPC:  res = pc + {w[31:12], 12'h0};
                OPC_JAL: begin
                    res = pc + 32'd4;
                    npc = pc + j_imm(w);
                end
                OPC_JALR: begin
                    res = pc + 32'd4;
                    npc = (rs1v + i_imm(w)) & ~32'd1;
                end
                OPC_LOAD: begin
                    addr = rs1v + i_imm(w);
                    res = m_dmem[addr[7:2]];
                end
                OPC_STORE: begin
                    wr = 1'b0;
                    addr = rs1v + s_imm(w);
                    m_dmem[addr[7:2]] = m_regs[w[24:20]];
                    i_rv_core_checker.push_store(addr, m_regs[w[24:20]], WMASK_WORD);
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) m_regs[w[11:7]] = res;
            pc = npc;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
        inst = imem[inst_addr[7:2]];
    endtask

    task automatic hold_reset();
        rst_n = 1'b0;
        repeat (16) tick();
    endtask

    // release reset, let n instructions retire, then reset again
    task automatic run_program(input int n);
        model_run(n);
        inst = imem[inst_addr[7:2]];
        rst_n = 1'b1;
        repeat (n + 1) tick();
        rst_n = 1'b0;
    endtask

    task automatic load_data();
        logic [31:0] fill;
        for (int i = 0; i < 64; i++) begin
            fill = 32'h6C00_0000 ^ (i * 32'h0104_1041);
            dmem[i] = fill;
            m_dmem[i] = fill;
        end
    endtask

    task automatic clear_prog();
        for (int i = 0; i < 64; i++) imem[i] = NOP;
    endtask

    // memory accesses use base x0 and jumps land inside the 64 slots
    task automatic gen_random_prog();
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [31:0] off;
        for (int s = 0; s < 64; s++) begin
            kind = rand_bits(3);
            rd = rand_bits(5);
            rs = rand_bits(5);
            case (kind)
                3'd0, 3'd1: imem[s] = itype_word(OPC_OP_IMM, F3_ADDI, rd, rs, rand_bits(12));
                3'd2: imem[s] = utype_word(OPC_LUI, rd, rand_bits(20));
                3'd3: imem[s] = utype_word(OPC_AUIPC, rd, rand_bits(20));
                3'd4: imem[s] = sw_word(rs, 5'd0, rand_bits(6) << 2);
                3'd5: imem[s] = itype_word(OPC_LOAD, F3_LW, rd, 5'd0, rand_bits(6) << 2);
                3'd6: begin
                    off = (rand_bits(6) - s) << 2;
                    imem[s] = jal_word(rd, off);
                end
                default: begin
                    off = (rand_bits(6) << 2) | rand_bits(1);
                    imem[s] = itype_word(OPC_JALR, F3_JALR, rd, 5'd0, off);
                end
            endcase
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        i_rv_core_checker.close_test(errs);
        tests_run++;
        total_errors += errs;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        inst = NOP;
        lfsr = 16'd41;
        tests_run = 0;
        tests_failed = 0;
        total_errors = 0;
        clear_prog();
        load_data();

        // addi, lui, auipc and a write to x0 whose results are all stored back
        hold_reset();
        clear_prog();
        imem[0] = itype_word(OPC_OP_IMM, F3_ADDI, 5'd1, 5'd0, 32'h123);
        imem[1] = itype_word(OPC_OP_IMM, F3_ADDI, 5'd2, 5'd1, 32'hFFFF_FFFB);
        imem[2] = utype_word(OPC_LUI, 5'd3, 32'hABCDE);
        imem[3] = utype_word(OPC_AUIPC, 5'd4, 32'h12345);
        imem[4] = itype_word(OPC_OP_IMM, F3_ADDI, 5'd0, 5'd1, 32'd77);
        for (int i = 0; i < 5; i++) imem[5 + i] = sw_word(i[4:0], 5'd0, i * 4);
        load_data();
        run_program(LEN_ALU);
        report_test("alu_store");

        // a store at the reset address must not fire before the core runs
        hold_reset();
        clear_prog();
        imem[0] = sw_word(5'd0, 5'd0, 32'd48);
        imem[1] = utype_word(OPC_LUI, 5'd5, 32'h5A5A5);
        imem[2] = itype_word(OPC_OP_IMM, F3_ADDI, 5'd5, 5'd5, 32'h3C3);
        imem[3] = sw_word(5'd5, 5'd0, 32'd32);
        imem[4] = itype_word(OPC_LOAD, F3_LW, 5'd6, 5'd0, 32'd32);
        imem[5] = sw_word(5'd6, 5'd0, 32'd36);
        imem[6] = itype_word(OPC_LOAD, F3_LW, 5'd7, 5'd0, 32'd40);
        imem[7] = sw_word(5'd7, 5'd0, 32'd44);
        load_data();
        run_program(LEN_MEM);
        report_test("store_load");

        // jalr target 0x31 has bit 0 set
        hold_reset();
        clear_prog();
        imem[0] = jal_word(5'd1, 32'd12);
        imem[3] = itype_word(OPC_OP_IMM, F3_ADDI, 5'd2, 5'd0, 32'h31);
        imem[4] = itype_word(OPC_JALR, F3_JALR, 5'd3, 5'd2, 32'd0);
        imem[12] = sw_word(5'd1, 5'd0, 32'd64);
        imem[13] = sw_word(5'd3, 5'd0, 32'd68);
        imem[14] = jal_word(5'd5, 32'd8);
        imem[16] = sw_word(5'd5, 5'd0, 32'd72);
        load_data();
        run_program(LEN_JMP);
        report_test("jal_jalr");

        hold_reset();
        gen_random_prog();
        load_data();
        run_program(LEN_RAND);
        report_test("random");

        // reset halfway while the data memory keeps its contents
        hold_reset();
        gen_random_prog();
        load_data();
        run_program(LEN_HALF);
        hold_reset();
        run_program(LEN_HALF);
        report_test("random_reset");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
